/* bench/cpu_tb.sv */
module cpu_tb;
    import cpu_pkg::*;

    localparam int ADDR_W = 10;
    localparam int MEM_WORDS = 1 << ADDR_W;

    logic                  clk;
    logic                  rst;
    logic                  halt_button;
    logic [WORD_W-1:0]     imem_data;
    logic [WORD_W-1:0]     dmem_rdata;
    logic [ADDR_W-1:0]     imem_addr;
    logic [ADDR_W-1:0]     dmem_addr;
    logic [WORD_W-1:0]     dmem_wdata;
    logic                  dmem_we;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [WORD_W-1:0]     rf_wdata;
    logic                  halted;

    logic [WORD_W-1:0]     imem [MEM_WORDS];
    logic [WORD_W-1:0]     dmem [MEM_WORDS];
    // reference state built alongside the program
    logic [WORD_W-1:0]     mdmem [MEM_WORDS];
    logic [WORD_W-1:0]     mreg [NUM_REGS];
    logic [REG_ADDR_W-1:0] exp_waddr [$];
    logic [WORD_W-1:0]     exp_wdata [$];
    logic [ADDR_W-1:0]     exp_maddr [$];
    logic [WORD_W-1:0]     exp_mdata [$];
    int                    wr_cycles [$];
    int                    pc_fill;
    int                    cycle;
    logic                  live;

    tb_clock #(.PERIOD(8)) u_tb_clock (.clk(clk));

    cpu_core #(
        .ADDR_W (ADDR_W)
    ) u_cpu_core (
        .clk         (clk),
        .rst         (rst),
        .halt_button (halt_button),
        .imem_data   (imem_data),
        .dmem_rdata  (dmem_rdata),
        .imem_addr   (imem_addr),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_we     (dmem_we),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .halted      (halted)
    );

    // both memories read combinationally
    assign imem_data  = imem[imem_addr];
    assign dmem_rdata = dmem[dmem_addr];

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (dmem_we === 1'b1)
        begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
        if (exp !== act)
        begin
            $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_reg_addr(input string name, input logic [REG_ADDR_W-1:0] exp,
                                  input logic [REG_ADDR_W-1:0] act);
        if (exp !== act)
        begin
            $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // write monitor sampled mid cycle
    always @(negedge clk)
    begin
        if (!rst && rf_we === 1'b1)
        begin
            if (exp_waddr.size() == 0)
            begin
                $display("unexpected register write to r%0d at time %0t", rf_waddr, $time);
                abort_run();
            end
            else
            begin
                check_reg_addr("rf_waddr", exp_waddr.pop_front(), rf_waddr);
                check_word("rf_wdata", exp_wdata.pop_front(), rf_wdata);
                wr_cycles.push_back(cycle);
            end
        end
        if (!rst && dmem_we === 1'b1)
        begin
            if (exp_maddr.size() == 0)
            begin
                $display("unexpected memory write to %h at time %0t", dmem_addr, $time);
                abort_run();
            end
            else
            begin
                check_word("dmem_addr", {{(WORD_W-ADDR_W){1'b0}}, exp_maddr.pop_front()},
                           {{(WORD_W-ADDR_W){1'b0}}, dmem_addr});
                check_word("dmem_wdata", exp_mdata.pop_front(), dmem_wdata);
            end
        end
    end

    function automatic logic [WORD_W-1:0] sext16(input logic [15:0] v);
        return {{(WORD_W-16){v[15]}}, v};
    endfunction

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = $urandom;
        return r[15:0];
    endfunction

    function automatic logic [WORD_W-1:0] alu_model(input logic [2:0] op,
                                                    input logic [WORD_W-1:0] a,
                                                    input logic [WORD_W-1:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_NOR: return ~(a | b);
            ALU_SLA: return a << b[4:0];
            default: return $signed(a) >>> b[4:0];
        endcase
    endfunction

    task automatic put(input logic [WORD_W-1:0] w);
        imem[pc_fill] = w;
        pc_fill++;
    endtask

    // skipped code is placed but leaves the reference untouched
    task automatic expect_reg(input logic [REG_ADDR_W-1:0] r, input logic [WORD_W-1:0] v);
        if (live)
        begin
            mreg[r] = v;
            exp_waddr.push_back(r);
            exp_wdata.push_back(v);
        end
    endtask

    task automatic emit_alu_rr(input logic [2:0] op, input logic [3:0] rd,
                               input logic [3:0] rs, input logic [3:0] rt);
        put({OP_ALU, rs, rt, rd, 12'h000, 2'b00, op});
        expect_reg(rd, alu_model(op, mreg[rs], mreg[rt]));
    endtask

    task automatic emit_alu_ri(input logic [2:0] op, input logic [3:0] rt,
                               input logic [3:0] rs, input logic [15:0] imm);
        put({OP_ALU, rs, rt, imm, 2'b10, op});
        expect_reg(rt, alu_model(op, mreg[rs], sext16(imm)));
    endtask

    task automatic emit_store(input logic [3:0] rt, input logic [3:0] rs,
                              input logic [15:0] off);
        logic [WORD_W-1:0] ea;
        ea = mreg[rs] + sext16(off);
        put({OP_LDST, rs, rt, off, 5'b00001});
        if (live)
        begin
            mdmem[ea[ADDR_W-1:0]] = mreg[rt];
            exp_maddr.push_back(ea[ADDR_W-1:0]);
            exp_mdata.push_back(mreg[rt]);
        end
    endtask

    task automatic emit_load(input logic [3:0] rt, input logic [3:0] rs,
                             input logic [15:0] off);
        logic [WORD_W-1:0] ea;
        ea = mreg[rs] + sext16(off);
        put({OP_LDST, rs, rt, off, 5'b00000});
        expect_reg(rt, mdmem[ea[ADDR_W-1:0]]);
    endtask

    task automatic emit_move(input logic [3:0] rt, input logic [3:0] rs);
        put({OP_MOVE, rs, rt, 21'h0});
        expect_reg(rt, mreg[rs]);
    endtask

    // branch over skip filler words that each add a random value to r5
    task automatic emit_branch(input logic [1:0] cond, input logic [3:0] rs, input int skip);
        logic signed [WORD_W-1:0] v;
        logic [22:0]              off;
        logic                     taken;
        v = mreg[rs];
        off = skip + 1;
        case (cond)
            COND_ALWAYS: taken = 1'b1;
            COND_NEG:    taken = (v < 0);
            COND_POS:    taken = (v > 0);
            default:     taken = (v == 0);
        endcase
        put({OP_BRANCH, rs, off, cond});
        live = !taken;
        for (int i = 0; i < skip; i++)
        begin
            emit_alu_ri(ALU_ADD, 4'd5, 4'd5, rand16());
        end
        live = 1'b1;
    endtask

    task automatic begin_test();
        logic [WORD_W-1:0] fill;
        pc_fill = 0;
        live = 1'b1;
        halt_button = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            fill = {i[9:0], 6'h2b, ~i[9:0], 6'h15};
            imem[i] = {OP_HALT, 19'h0, i[9:0]};
            dmem[i] <= fill;
            mdmem[i] = fill;
        end
        for (int i = 0; i < NUM_REGS; i++)
        begin
            mreg[i] = '0;
        end
        exp_waddr.delete();
        exp_wdata.delete();
        exp_maddr.delete();
        exp_mdata.delete();
        wr_cycles.delete();
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic run_to_halt(input int pause_cycles);
        int                limit;
        int                n;
        logic [ADDR_W-1:0] held_addr;
        limit = 5 * pc_fill + pause_cycles + 50;
        n = 0;
        while (halted !== 1'b1)
        begin
            @(posedge clk);
            #1;
            n++;
            if (n > limit)
            begin
                $display("timeout: the CPU did not halt within %0d cycles", limit);
                abort_run();
            end
        end
        // halted is terminal so the pc must freeze
        held_addr = imem_addr;
        repeat (20)
        begin
            @(posedge clk);
            #1;
            if (halted !== 1'b1)
            begin
                $display("halted dropped at time %0t without a reset", $time);
                abort_run();
            end
            check_word("imem_addr", {{(WORD_W-ADDR_W){1'b0}}, held_addr},
                       {{(WORD_W-ADDR_W){1'b0}}, imem_addr});
        end
        if (exp_waddr.size() != 0 || exp_maddr.size() != 0)
        begin
            $display("%0d register and %0d memory writes expected but never seen",
                     exp_waddr.size(), exp_maddr.size());
            abort_run();
        end
    endtask

    task automatic test_alu_ops();
        begin_test();
        emit_alu_ri(ALU_ADD, 4'd1, 4'd0, rand16());
        emit_alu_ri(ALU_SLA, 4'd1, 4'd1, 16'd11);
        emit_alu_ri(ALU_XOR, 4'd1, 4'd1, rand16());
        emit_alu_ri(ALU_ADD, 4'd2, 4'd0, rand16());
        for (int k = 0; k < 8; k++)
        begin
            emit_alu_rr(k[2:0], k[3:0] + 4'd3, 4'd1, 4'd2);
        end
        for (int k = 0; k < 8; k++)
        begin
            emit_alu_ri(k[2:0], 4'd11, 4'd1, rand16());
        end
        reset_dut();
        run_to_halt(0);
    endtask

    task automatic test_load_store();
        logic [15:0] base;
        logic [15:0] off;
        base = rand16();
        off = rand16();
        begin_test();
        emit_alu_ri(ALU_ADD, 4'd1, 4'd0, {8'h00, base[7:0]});
        emit_alu_ri(ALU_ADD, 4'd2, 4'd0, rand16());
        emit_alu_ri(ALU_SLA, 4'd2, 4'd2, 16'd9);
        emit_store(4'd2, 4'd1, off);
        emit_load(4'd3, 4'd1, off);
        // negative offset then a read back through the same base
        emit_store(4'd1, 4'd2, 16'hfff0);
        emit_load(4'd4, 4'd0, 16'h0123);
        emit_load(4'd5, 4'd2, 16'hfff0);
        reset_dut();
        run_to_halt(0);
    endtask

    task automatic test_branches();
        logic [15:0] r;
        r = rand16();
        begin_test();
        emit_alu_ri(ALU_ADD, 4'd1, 4'd0, {1'b1, r[14:0]});
        emit_alu_ri(ALU_ADD, 4'd2, 4'd0, {1'b0, r[14:1], 1'b1});
        emit_branch(COND_ALWAYS, 4'd0, 2);
        emit_branch(COND_NEG, 4'd1, 2);
        emit_branch(COND_NEG, 4'd2, 1);
        emit_branch(COND_POS, 4'd2, 2);
        emit_branch(COND_POS, 4'd0, 1);
        emit_branch(COND_POS, 4'd1, 1);
        emit_branch(COND_ZERO, 4'd0, 3);
        emit_branch(COND_ZERO, 4'd2, 1);
        // r5 sums only the fillers that ran
        emit_alu_ri(ALU_ADD, 4'd6, 4'd5, 16'd1);
        reset_dut();
        run_to_halt(0);
    endtask

    task automatic test_move_nop();
        logic [31:0] r;
        r = $urandom;
        begin_test();
        emit_alu_ri(ALU_ADD, 4'd1, 4'd0, rand16());
        emit_alu_ri(ALU_SLA, 4'd1, 4'd1, 16'd7);
        emit_move(4'd2, 4'd1);
        put({3'b011, r[28:0]});
        put({3'b110, ~r[28:0]});
        put({OP_CTRL, 4'h0, 25'h0});
        emit_move(4'd3, 4'd2);
        reset_dut();
        run_to_halt(0);
    endtask

    task automatic test_pause();
        int n;
        n = $urandom_range(3, 12);
        begin_test();
        emit_alu_ri(ALU_ADD, 4'd1, 4'd0, rand16());
        put({OP_CTRL, 4'h8, 25'h0});
        emit_alu_ri(ALU_ADD, 4'd2, 4'd1, rand16());
        halt_button = 1'b1;
        reset_dut();
        fork
            run_to_halt(n + 1);
            begin
                while (wr_cycles.size() < 1)
                begin
                    @(posedge clk);
                    #1;
                end
                // sampled high in decode for exactly n extra cycles
                repeat (n + 1) @(posedge clk);
                #1;
                halt_button = 1'b0;
            end
        join
        check_word("pause write gap", 10 + n, wr_cycles[1] - wr_cycles[0]);
    endtask

    initial
    begin
        rst = 1'b1;
        halt_button = 1'b0;
        void'($urandom(32'h7400_6d00));
        test_alu_ops();
        test_load_store();
        test_branches();
        test_move_nop();
        test_pause();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    // free running, half period per level
    always #(PERIOD / 2) clk = ~clk;

endmodule

/* build.f */
src/cpu_pkg.sv
src/alu.sv
src/register_file.sv
src/instr_fetch.sv
src/cycle_control.sv
src/execute_unit.sv
src/cpu_core.sv
bench/tb_clock.sv
bench/cpu_tb.sv

/* src/alu.sv */
module alu (
    input  logic [cpu_pkg::WORD_W-1:0] a,
    input  logic [cpu_pkg::WORD_W-1:0] b,
    input  logic [2:0]                 op,
    output logic [cpu_pkg::WORD_W-1:0] y
);
    import cpu_pkg::*;

    // shift amount from the low bits of b only
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb
    begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_NOR: y = ~(a | b);
            ALU_SLA: y = a << shamt;
            ALU_SRA: y = $signed(a) >>> shamt;
            default: y = a + b;
        endcase
    end

endmodule

/* src/cpu_core.sv */
module cpu_core #(
    parameter int ADDR_W = 10
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           halt_button,
    input  logic [cpu_pkg::WORD_W-1:0]     imem_data,
    input  logic [cpu_pkg::WORD_W-1:0]     dmem_rdata,
    output logic [ADDR_W-1:0]              imem_addr,
    output logic [ADDR_W-1:0]              dmem_addr,
    output logic [cpu_pkg::WORD_W-1:0]     dmem_wdata,
    output logic                           dmem_we,
    output logic                           rf_we,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rf_waddr,
    output logic [cpu_pkg::WORD_W-1:0]     rf_wdata,
    output logic                           halted
);
    import cpu_pkg::*;

    logic                  fetch_en;
    logic                  decode_en;
    logic                  execute_en;
    logic                  memory_en;
    logic                  writeback_en;
    logic                  branch_taken;
    instr_t                ir;
    logic [REG_ADDR_W-1:0] raddr_a;
    logic [REG_ADDR_W-1:0] raddr_b;
    logic [WORD_W-1:0]     rdata_a;
    logic [WORD_W-1:0]     rdata_b;

    cycle_control u_cycle_control (
        .clk          (clk),
        .rst          (rst),
        .halt_button  (halt_button),
        .ir           (ir),
        .fetch_en     (fetch_en),
        .decode_en    (decode_en),
        .execute_en   (execute_en),
        .memory_en    (memory_en),
        .writeback_en (writeback_en),
        .halted       (halted)
    );

    instr_fetch #(
        .ADDR_W (ADDR_W)
    ) u_instr_fetch (
        .clk          (clk),
        .rst          (rst),
        .fetch_en     (fetch_en),
        .memory_en    (memory_en),
        .branch_taken (branch_taken),
        .imem_data    (imem_data),
        .imem_addr    (imem_addr),
        .ir           (ir)
    );

    // writeback bus is shared with the top-level ports
    register_file u_register_file (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    execute_unit #(
        .ADDR_W (ADDR_W)
    ) u_execute_unit (
        .clk          (clk),
        .rst          (rst),
        .ir           (ir),
        .decode_en    (decode_en),
        .execute_en   (execute_en),
        .memory_en    (memory_en),
        .writeback_en (writeback_en),
        .rdata_a      (rdata_a),
        .rdata_b      (rdata_b),
        .dmem_rdata   (dmem_rdata),
        .raddr_a      (raddr_a),
        .raddr_b      (raddr_b),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_we      (dmem_we),
        .branch_taken (branch_taken)
    );

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

    // word and register bank sizes
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 4;
    localparam int NUM_REGS   = 16;

    // major opcodes, 011 and 110 fall through as no-ops
    localparam logic [2:0] OP_ALU    = 3'b000;
    localparam logic [2:0] OP_LDST   = 3'b001;
    localparam logic [2:0] OP_BRANCH = 3'b010;
    localparam logic [2:0] OP_MOVE   = 3'b100;
    localparam logic [2:0] OP_CTRL   = 3'b101;
    localparam logic [2:0] OP_HALT   = 3'b111;

    // alu operations, taken from funct[2:0]
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;
    localparam logic [2:0] ALU_NOR = 3'd5;
    localparam logic [2:0] ALU_SLA = 3'd6;
    localparam logic [2:0] ALU_SRA = 3'd7;

    // branch conditions on rs
    localparam logic [1:0] COND_ALWAYS = 2'b00;
    localparam logic [1:0] COND_NEG    = 2'b01;
    localparam logic [1:0] COND_POS    = 2'b10;
    localparam logic [1:0] COND_ZERO   = 2'b11;

    // one instruction word, two decodings
    typedef union packed {
        // alu, load/store and move
        struct packed {
            logic [2:0]            opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            // top nibble doubles as rd
            logic [15:0]           imm16;
            // bit 4 immediate form, bits 2..0 alu op, bit 0 store
            logic [4:0]            funct;
        } r;
        // branches and program control
        struct packed {
            logic [2:0]            opcode;
            // rs[3] is the pause flag of program control
            logic [REG_ADDR_W-1:0] rs;
            logic [22:0]           imm23;
            logic [1:0]            funct2;
        } b;
    } instr_t;

endpackage

/* src/cycle_control.sv */
module cycle_control (
    input  logic            clk,
    input  logic            rst,
    input  logic            halt_button,
    input  cpu_pkg::instr_t ir,
    output logic            fetch_en,
    output logic            decode_en,
    output logic            execute_en,
    output logic            memory_en,
    output logic            writeback_en,
    output logic            halted
);
    import cpu_pkg::*;

    localparam logic [2:0] S_FETCH     = 3'd0;
    localparam logic [2:0] S_DECODE    = 3'd1;
    localparam logic [2:0] S_EXECUTE   = 3'd2;
    localparam logic [2:0] S_MEMORY    = 3'd3;
    localparam logic [2:0] S_WRITEBACK = 3'd4;
    localparam logic [2:0] S_HALT      = 3'd5;

    logic [2:0] state;
    logic       is_halt;
    logic       is_pause;

    assign is_halt  = (ir.r.opcode == OP_HALT);
    // pause flag sits in rs[3] of program control
    assign is_pause = (ir.b.opcode == OP_CTRL) && ir.b.rs[3] && halt_button;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= S_FETCH;
        end
        else
        begin
            case (state)
                S_FETCH:     state <= S_DECODE;
                S_DECODE:
                begin
                    if (is_halt)
                    begin
                        state <= S_HALT;
                    end
                    else if (!is_pause)
                    begin
                        state <= S_EXECUTE;
                    end
                end
                S_EXECUTE:   state <= S_MEMORY;
                S_MEMORY:    state <= S_WRITEBACK;
                S_WRITEBACK: state <= S_FETCH;
                // terminal until reset
                S_HALT:      state <= S_HALT;
                default:     state <= S_FETCH;
            endcase
        end
    end

    assign fetch_en     = (state == S_FETCH);
    assign decode_en    = (state == S_DECODE);
    assign execute_en   = (state == S_EXECUTE);
    assign memory_en    = (state == S_MEMORY);
    assign writeback_en = (state == S_WRITEBACK);
    assign halted       = (state == S_HALT);

    a_one_phase: assert property (
        @(posedge clk) disable iff (rst)
        $onehot({fetch_en, decode_en, execute_en, memory_en, writeback_en, halted})
    );

endmodule

/* src/execute_unit.sv */
module execute_unit #(
    parameter int ADDR_W = 10
) (
    input  logic                           clk,
    input  logic                           rst,
    input  cpu_pkg::instr_t                ir,
    input  logic                           decode_en,
    input  logic                           execute_en,
    input  logic                           memory_en,
    input  logic                           writeback_en,
    input  logic [cpu_pkg::WORD_W-1:0]     rdata_a,
    input  logic [cpu_pkg::WORD_W-1:0]     rdata_b,
    input  logic [cpu_pkg::WORD_W-1:0]     dmem_rdata,
    output logic [cpu_pkg::REG_ADDR_W-1:0] raddr_a,
    output logic [cpu_pkg::REG_ADDR_W-1:0] raddr_b,
    output logic                           rf_we,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rf_waddr,
    output logic [cpu_pkg::WORD_W-1:0]     rf_wdata,
    output logic [ADDR_W-1:0]              dmem_addr,
    output logic [cpu_pkg::WORD_W-1:0]     dmem_wdata,
    output logic                           dmem_we,
    output logic                           branch_taken
);
    import cpu_pkg::*;

    logic [WORD_W-1:0] opnd_a;
    logic [WORD_W-1:0] opnd_b;
    logic [WORD_W-1:0] alu_out;
    logic [WORD_W-1:0] lmd;
    logic [WORD_W-1:0] imm_ext;
    logic [WORD_W-1:0] alu_b;
    logic [WORD_W-1:0] alu_y;
    logic [2:0]        alu_op;
    logic              is_alu;
    logic              is_imm;
    logic              is_load;
    logic              is_store;
    logic              is_move;
    logic              is_branch;
    logic              cond_met;

    assign is_alu    = (ir.r.opcode == OP_ALU);
    assign is_imm    = is_alu && ir.r.funct[4];
    assign is_load   = (ir.r.opcode == OP_LDST) && !ir.r.funct[0];
    assign is_store  = (ir.r.opcode == OP_LDST) && ir.r.funct[0];
    assign is_move   = (ir.r.opcode == OP_MOVE);
    assign is_branch = (ir.b.opcode == OP_BRANCH);

    assign raddr_a = ir.r.rs;
    assign raddr_b = ir.r.rt;

    assign imm_ext = {{(WORD_W-16){ir.r.imm16[15]}}, ir.r.imm16};

    // second operand: immediate for loads, stores and imm form, zero for move
    always_comb
    begin
        if (is_imm || is_load || is_store)
        begin
            alu_b = imm_ext;
        end
        else if (is_move)
        begin
            alu_b = '0;
        end
        else
        begin
            alu_b = opnd_b;
        end
    end

    assign alu_op = is_alu ? ir.r.funct[2:0] : ALU_ADD;

    alu u_alu (
        .a  (opnd_a),
        .b  (alu_b),
        .op (alu_op),
        .y  (alu_y)
    );

    always_comb
    begin
        case (ir.b.funct2)
            COND_ALWAYS: cond_met = 1'b1;
            COND_NEG:    cond_met = opnd_a[WORD_W-1];
            COND_POS:    cond_met = !opnd_a[WORD_W-1] && (opnd_a != '0);
            COND_ZERO:   cond_met = (opnd_a == '0);
            default:     cond_met = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (decode_en)
        begin
            opnd_a <= rdata_a;
            opnd_b <= rdata_b;
        end
        if (execute_en)
        begin
            alu_out <= alu_y;
        end
        if (memory_en)
        begin
            lmd <= dmem_rdata;
        end
    end

    // held until the next execute phase so fetch sees it in memory
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            branch_taken <= 1'b0;
        end
        else if (execute_en)
        begin
            branch_taken <= is_branch && cond_met;
        end
    end

    // address and store data settle in execute
    assign dmem_addr  = alu_out[ADDR_W-1:0];
    assign dmem_wdata = opnd_b;
    assign dmem_we    = memory_en && is_store;

    // register form writes rd, everything else writes rt
    assign rf_we    = writeback_en && (is_alu || is_load || is_move);
    assign rf_waddr = (is_alu && !is_imm) ? ir.r.imm16[15:12] : ir.r.rt;
    assign rf_wdata = is_load ? lmd : alu_out;

    a_no_dual_write: assert property (
        @(posedge clk) disable iff (rst) !(dmem_we && rf_we)
    );

endmodule

/* src/instr_fetch.sv */
module instr_fetch #(
    parameter int ADDR_W = 10
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetch_en,
    input  logic                       memory_en,
    input  logic                       branch_taken,
    input  logic [cpu_pkg::WORD_W-1:0] imem_data,
    output logic [ADDR_W-1:0]          imem_addr,
    output cpu_pkg::instr_t            ir
);
    import cpu_pkg::*;

    logic [ADDR_W-1:0] pc;
    logic [WORD_W-1:0] branch_off;
    logic [WORD_W-1:0] branch_target;

    assign imem_addr = pc;

    // target is relative to the pc of the branch itself
    assign branch_off    = {{(WORD_W-23){ir.b.imm23[22]}}, ir.b.imm23};
    assign branch_target = {{(WORD_W-ADDR_W){1'b0}}, pc} + branch_off;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= '0;
        end
        else if (memory_en)
        begin
            if (branch_taken)
            begin
                pc <= branch_target[ADDR_W-1:0];
            end
            else
            begin
                pc <= pc + 1'b1;
            end
        end
    end

    // instruction memory is word addressed and reads combinationally
    always_ff @(posedge clk)
    begin
        if (fetch_en)
        begin
            ir <= imem_data;
        end
    end

endmodule

/* src/register_file.sv */
module register_file (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr_a,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr_b,
    input  logic                           we,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [cpu_pkg::WORD_W-1:0]     wdata,
    output logic [cpu_pkg::WORD_W-1:0]     rdata_a,
    output logic [cpu_pkg::WORD_W-1:0]     rdata_b
);
    import cpu_pkg::*;

    logic [WORD_W-1:0] regs [NUM_REGS];

    // both read ports are asynchronous
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we)
        begin
            regs[waddr] <= wdata;
        end
    end

    // the write index comes from a decoded field of the latched word
    a_waddr_known: assert property (
        @(posedge clk) disable iff (rst) we |-> !$isunknown(waddr)
    );

endmodule
